// ==== Makefile ====
# Verilator build and run of the RTC overlay testbench

VERILATOR ?= verilator
TOP       ?= clockDisplayTb
RTL_TOP   ?= clockDisplay
FILELIST  ?= clockDisplay.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "Run reported a failure"; exit 1; fi
	@grep -q "Simulation passed" $(LOG) || { echo "Run ended without a result"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== clockDisplay.f ====
displayPkg.sv
scanTiming.sv
fieldDecoder.sv
glyphRom.sv
pixelOutput.sv
clockDisplay.sv
clockDisplayTb.sv

// ==== clockDisplay.sv ====
// Top level of the RTC overlay: scan generator, field decoder, glyph ROM and pixel output
`timescale 1ns/1ps
`default_nettype none

module clockDisplay
(
	input  wire                      CLK,
	input  wire                      rst,
	input  wire displayPkg::rtcDateT date,       // Day, month, year in BCD
	input  wire displayPkg::rtcTimeT clockTime,  // Current time in BCD
	input  wire displayPkg::rtcTimeT timerTime,  // Timer value in BCD
	output wire                      pixelTick,
	output wire displayPkg::colorT   COLOR,
	output wire                      HS,
	output wire                      VS,
	output wire                      videoOn,
	output wire displayPkg::coordT   pixelX,
	output wire displayPkg::coordT   pixelY
);

	////////////////////////////////////////
	// Pipeline links
	wire displayPkg::scanT      scan;           // Producer to decoder
	wire displayPkg::glyphReqT  req;            // Decoder to ROM
	wire displayPkg::glyphWordT word;           // ROM to output stage

	scanTiming scanGen
	(
		.CLK       (CLK),
		.rst       (rst),
		.pixelTick (pixelTick),
		.scan      (scan)
	);

	fieldDecoder decoder
	(
		.CLK       (CLK),
		.rst       (rst),
		.pixelTick (pixelTick),
		.scan      (scan),
		.date      (date),
		.clockTime (clockTime),
		.timerTime (timerTime),
		.req       (req)
	);

	glyphRom glyphs
	(
		.CLK       (CLK),
		.pixelTick (pixelTick),
		.req       (req),
		.word      (word)
	);

	pixelOutput outStage
	(
		.CLK       (CLK),
		.rst       (rst),
		.pixelTick (pixelTick),
		.word      (word),
		.COLOR     (COLOR),
		.HS        (HS),
		.VS        (VS),
		.videoOn   (videoOn),
		.pixelX    (pixelX),
		.pixelY    (pixelY)
	);

endmodule

`default_nettype wire

// ==== clockDisplayTb.sv ====
// RTC overlay testbench with clock, reset, random BCD stimulus, colour model and assertions
`timescale 1ns/1ps
`default_nettype none

module clockDisplayTb;

	localparam int vsTimeout = 900000;              // Somewhat more CLK cycles than one frame
	localparam int cellRowY [0:2] = '{20, 70, 140};  // Cell offsets inside the panel
	localparam int cellColX [0:5] = '{20, 45, 80, 105, 140, 165};

	logic CLK;
	logic rst;
	displayPkg::rtcDateT date;
	displayPkg::rtcTimeT clockTime;
	displayPkg::rtcTimeT timerTime;
	logic pixelTick;
	displayPkg::colorT COLOR;
	logic HS;
	logic VS;
	logic videoOn;
	displayPkg::coordT pixelX;
	displayPkg::coordT pixelY;

	logic [7:0] glyphs [0:79];                       // Model copy of the glyph data
	int tickCount;                                   // Saturating count of pixel ticks since reset
	logic resetSeen;
	int lastX;                                       // Output position at the previous tick
	int lastY;

	clockDisplay UUT
	(
		.CLK       (CLK),
		.rst       (rst),
		.date      (date),
		.clockTime (clockTime),
		.timerTime (timerTime),
		.pixelTick (pixelTick),
		.COLOR     (COLOR),
		.HS        (HS),
		.VS        (VS),
		.videoOn   (videoOn),
		.pixelX    (pixelX),
		.pixelY    (pixelY)
	);

	initial
	begin
		CLK = 1'b0;
	end

	always #10 CLK = ~CLK;                           // 20 ns period

	initial
	begin
		$readmemh("digitGlyphs.mem", glyphs);
	end

	////////////////////////////////////////
	// Helpers
	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// Expected colour of one output pixel
	function automatic logic [11:0] expectColor(input int x, input int y,
		input logic [23:0] dateV, input logic [23:0] timeV, input logic [23:0] timerV);
		logic [23:0] rowVal;
		logic [7:0] bits;
		int relX;
		int relY;
		int row;
		int col;
		int nib;
		if (!((x < 640) && (y < 480)))
			return 12'h000;                          // Blanking
		if ((x < 100) || (x >= 300) || (y < 100) || (y >= 300))
			return 12'hFFF;                          // Outside the panel
		relX = x - 100;
		relY = y - 100;
		row = -1;
		col = -1;
		for (int r = 0; r < 3; r++)
			if ((relY >= cellRowY[r]) && (relY < cellRowY[r] + 16))
				row = r;
		for (int c = 0; c < 6; c++)
			if ((relX >= cellColX[c]) && (relX < cellColX[c] + 16))
				col = c;
		if ((row < 0) || (col < 0))
			return 12'h236;                          // Panel background
		rowVal = (row == 0) ? dateV : ((row == 1) ? timeV : timerV);
		nib = int'((rowVal >> (20 - 4 * col)) & 24'hF);  // Leftmost digit in the top nibble
		if (nib > 9)
			return 12'h236;                          // Non-BCD cell stays empty
		bits = glyphs[nib * 8 + (relY - cellRowY[row]) / 2];
		return bits[7 - (relX - cellColX[col]) / 2] ? 12'hFF0 : 12'h236;
	endfunction

	function automatic logic [7:0] randomByte(input bit anyNibble);
		if (anyNibble)
			return 8'($urandom % 256);               // Nibbles 0 to F
		return {4'($urandom % 10), 4'($urandom % 10)};
	endfunction

	task automatic drawInputs(input bit anyNibble);
		date.day          = randomByte(anyNibble);
		date.month        = randomByte(anyNibble);
		date.year         = randomByte(anyNibble);
		clockTime.hours   = randomByte(anyNibble);
		clockTime.minutes = randomByte(anyNibble);
		clockTime.seconds = randomByte(anyNibble);
		timerTime.hours   = randomByte(anyNibble);
		timerTime.minutes = randomByte(anyNibble);
		timerTime.seconds = randomByte(anyNibble);
		if (anyNibble)
			date.day[7:4] = 4'hC;                    // At least one cell above 9
	endtask

	task automatic waitForVs(input logic level);
		int cycles;
		cycles = 0;
		while ((VS !== level) && (cycles <= vsTimeout))
		begin
			@(negedge CLK);
			cycles++;
		end
		if (VS !== level)
			failRun($sformatf("Timeout: VS did not reach %0b within %0d cycles", level, vsTimeout));
	endtask

	////////////////////////////////////////
	// Tick bookkeeping
	always @(posedge CLK)
	begin
		if (rst)
		begin
			resetSeen <= 1'b1;
			tickCount <= 0;
		end
		else if (pixelTick && (tickCount < 15))
			tickCount <= tickCount + 1;              // Output valid from the fourth tick
		if (pixelTick)
		begin
			lastX <= int'(pixelX);
			lastY <= int'(pixelY);
		end
	end

	////////////////////////////////////////
	// Checks
	idleOutputs: assert property (@(posedge CLK) (resetSeen && (tickCount < 4)) |->
		(HS && VS && !videoOn && (COLOR == 12'h000)))
		else failRun($sformatf("ERROR at %0d ns: outputs not idle around reset", $time));

	tickToggle: assert property (@(posedge CLK) disable iff (rst)
		(tickCount >= 1) |-> (pixelTick != $past(pixelTick)))
		else failRun($sformatf("ERROR at %0d ns: pixelTick %0b on two CLK in a row", $time,
			$sampled(pixelTick)));

	hsWindow: assert property (@(posedge CLK) disable iff (rst)
		(pixelTick && (tickCount >= 4)) |-> (HS == !((pixelX >= 656) && (pixelX <= 751))))
		else failRun($sformatf("ERROR at %0d ns: HS %0b at pixelX %0d", $time,
			$sampled(HS), $sampled(pixelX)));

	vsWindow: assert property (@(posedge CLK) disable iff (rst)
		(pixelTick && (tickCount >= 4)) |-> (VS == !((pixelY == 490) || (pixelY == 491))))
		else failRun($sformatf("ERROR at %0d ns: VS %0b at pixelY %0d", $time,
			$sampled(VS), $sampled(pixelY)));

	videoWindow: assert property (@(posedge CLK) disable iff (rst)
		(pixelTick && (tickCount >= 4)) |-> (videoOn == ((pixelX < 640) && (pixelY < 480))))
		else failRun($sformatf("ERROR at %0d ns: videoOn %0b at (%0d,%0d)", $time,
			$sampled(videoOn), $sampled(pixelX), $sampled(pixelY)));

	xStep: assert property (@(posedge CLK) disable iff (rst)
		(pixelTick && (tickCount >= 5)) |-> (int'(pixelX) == ((lastX == 799) ? 0 : lastX + 1)))
		else failRun($sformatf("ERROR at %0d ns: pixelX %0d after %0d", $time,
			$sampled(pixelX), $sampled(lastX)));

	yStep: assert property (@(posedge CLK) disable iff (rst)
		(pixelTick && (tickCount >= 5)) |-> (int'(pixelY) == ((lastX != 799) ? lastY :
		((lastY == 524) ? 0 : lastY + 1))))
		else failRun($sformatf("ERROR at %0d ns: pixelY %0d after %0d", $time,
			$sampled(pixelY), $sampled(lastY)));

	colorMatch: assert property (@(posedge CLK) disable iff (rst)
		(pixelTick && (tickCount >= 4)) |->
		(COLOR == expectColor(int'(pixelX), int'(pixelY), date, clockTime, timerTime)))
		else failRun($sformatf("ERROR at %0d ns: COLOR %h at (%0d,%0d), expected %h", $time,
			$sampled(COLOR), $sampled(pixelX), $sampled(pixelY),
			expectColor(int'($sampled(pixelX)), int'($sampled(pixelY)), $sampled(date),
			$sampled(clockTime), $sampled(timerTime))));

	////////////////////////////////////////
	// Stimulus
	initial
	begin
		void'($urandom(58083));
		resetSeen = 1'b0;
		tickCount = 0;
		lastX = 0;
		lastY = 0;
		rst = 1'b1;
		drawInputs(1'b0);                            // First frame with plain BCD
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		rst = 1'b0;

		// Frame two has non-BCD nibbles and frame three plain BCD again
		for (int frame = 0; frame < 2; frame++)
		begin
			waitForVs(1'b0);
			@(negedge CLK);
			drawInputs(frame == 0);                  // Changed only inside the sync pulse
			waitForVs(1'b1);
		end
		waitForVs(1'b0);                             // End of the third frame

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== digitGlyphs.mem ====
// One 8-pixel glyph row per line as two hex digits, bit 7 is the leftmost pixel
// Rows 8n to 8n+7 hold digit n, top row first
3C // 0
66
6E
76
66
66
3C
00
18 // 1
38
18
18
18
18
7E
00
3C // 2
66
06
0C
30
60
7E
00
3C // 3
66
06
1C
06
66
3C
00
0C // 4
1C
3C
6C
7E
0C
0C
00
7E // 5
60
7C
06
06
66
3C
00
3C // 6
60
7C
66
66
66
3C
00
7E // 7
06
0C
18
30
30
30
00
3C // 8
66
66
3C
66
66
3C
00
3C // 9
66
66
3E
06
0C
38
00

// ==== displayPkg.sv ====
// Shared timing, layout and colour constants, plus the pixel pipeline structs and pixel class enum
`default_nettype none

package displayPkg;

	////////////////////////////////////////
	// Basic types
	typedef logic [9:0]  coordT;                        // Pixel coordinate
	typedef logic [11:0] colorT;                        // RGB 4:4:4
	typedef logic [7:0]  bcdByteT;                      // Two BCD digits, tens in the upper nibble

	////////////////////////////////////////
	// 640x480 timing
	localparam coordT hActive = 10'd640;                // Visible pixels per line
	localparam coordT hFront  = 10'd16;
	localparam coordT hSync   = 10'd96;
	localparam coordT hBack   = 10'd48;
	localparam coordT hTotal  = hActive + hFront + hSync + hBack; // 800
	localparam coordT vActive = 10'd480;                // Visible lines per frame
	localparam coordT vFront  = 10'd10;
	localparam coordT vSync   = 10'd2;
	localparam coordT vBack   = 10'd33;
	localparam coordT vTotal  = vActive + vFront + vSync + vBack; // 525

	localparam coordT hSyncStart = hActive + hFront;    // 656
	localparam coordT hSyncEnd   = hSyncStart + hSync;  // 752, first pixel past the pulse
	localparam coordT vSyncStart = vActive + vFront;    // 490
	localparam coordT vSyncEnd   = vSyncStart + vSync;  // 492

	localparam int pixelDivide    = 2;                  // CLK cycles per pixel
	localparam int pixelPhaseBits = (pixelDivide > 1) ? $clog2(pixelDivide) : 1;
	localparam logic [pixelPhaseBits-1:0] phaseLast = pixelPhaseBits'(pixelDivide - 1);

	////////////////////////////////////////
	// Panel and digit layout
	localparam coordT panelX    = 10'd100;              // Panel origin on screen
	localparam coordT panelY    = 10'd100;
	localparam coordT panelSize = 10'd200;              // Square panel

	localparam int    glyphSize  = 8;                   // ROM glyph is 8x8
	localparam int    glyphScale = 2;                   // Each glyph bit covers 2x2 pixels
	localparam int    glyphCount = 10;                  // Digits 0 to 9
	localparam int    glyphDepth = glyphCount * glyphSize; // ROM rows
	localparam coordT cellSize   = coordT'(glyphSize * glyphScale); // 16x16 cell

	// Cell offsets inside the panel; rows are date, time, timer
	localparam coordT digitRowY [0:2] = '{10'd20, 10'd70, 10'd140};
	localparam coordT digitColX [0:5] = '{10'd20, 10'd45, 10'd80, 10'd105, 10'd140, 10'd165};

	////////////////////////////////////////
	// Fixed colours
	localparam colorT colorBlank   = 12'h000;           // Blanking interval
	localparam colorT colorOutside = 12'hFFF;           // Screen outside the panel
	localparam colorT colorPanel   = 12'h236;           // Panel background and clear glyph bits
	localparam colorT colorInk     = 12'hFF0;           // Set glyph bits

	////////////////////////////////////////
	// RTC values
	typedef struct packed {
		bcdByteT hours;
		bcdByteT minutes;
		bcdByteT seconds;
	} rtcTimeT;

	typedef struct packed {
		bcdByteT day;
		bcdByteT month;
		bcdByteT year;
	} rtcDateT;

	////////////////////////////////////////
	// Pixel pipeline
	typedef struct packed {
		coordT x;
		coordT y;
		logic  hSync;                                   // Active low
		logic  vSync;                                   // Active low
		logic  videoOn;
	} scanT;

	typedef enum logic [1:0] {
		PIX_BLANK,
		PIX_OUTSIDE,
		PIX_PANEL,
		PIX_DIGIT
	} pixelClassT;

	typedef struct packed {
		scanT       scan;
		pixelClassT pixClass;
		logic [3:0] digit;                              // Glyph index, 0 unless PIX_DIGIT
		logic [2:0] glyphRow;
		logic [2:0] glyphCol;
	} glyphReqT;

	typedef struct packed {
		glyphReqT req;
		logic     glyphBit;                             // Selected glyph pixel
	} glyphWordT;

	// Idle values, syncs inactive and nothing visible
	localparam scanT scanIdle = '{x: '0, y: '0, hSync: 1'b1, vSync: 1'b1, videoOn: 1'b0};
	localparam glyphReqT reqIdle = '{scan: scanIdle, pixClass: PIX_BLANK, digit: '0,
		glyphRow: '0, glyphCol: '0};

endpackage

`default_nettype wire

// ==== fieldDecoder.sv ====
// Field decoder: panel and digit windows, BCD nibble select, glyph request register
`timescale 1ns/1ps
`default_nettype none

module fieldDecoder
(
	input  wire                     CLK,
	input  wire                     rst,
	input  wire                     pixelTick,
	input  wire displayPkg::scanT   scan,
	input  wire displayPkg::rtcDateT date,
	input  wire displayPkg::rtcTimeT clockTime,
	input  wire displayPkg::rtcTimeT timerTime,
	output displayPkg::glyphReqT    req         // Registered request for the glyph ROM
);

	logic [23:0] rowValue [0:2];                // Six digits per row, leftmost in the MSBs
	displayPkg::coordT relX;                    // Offset inside the panel
	displayPkg::coordT relY;
	logic inPanel;
	logic rowHit;
	logic colHit;
	logic [1:0] rowIdx;                         // 0 date, 1 time, 2 timer
	logic [2:0] colIdx;                         // Digit position 0..5
	logic [3:0] rowOff;                         // Pixel offset inside the 16x16 cell
	logic [3:0] colOff;
	logic [3:0] nibble;
	displayPkg::pixelClassT pixClass;

	assign rowValue[0] = date;
	assign rowValue[1] = clockTime;
	assign rowValue[2] = timerTime;

	assign relX = scan.x - displayPkg::panelX;
	assign relY = scan.y - displayPkg::panelY;
	assign inPanel = (scan.x >= displayPkg::panelX) && (relX < displayPkg::panelSize) &&
		(scan.y >= displayPkg::panelY) && (relY < displayPkg::panelSize);

	////////////////////////////////////////
	// Digit windows
	always_comb
	begin
		rowHit = 1'b0;
		rowIdx = '0;
		rowOff = '0;
		for (int r = 0; r < 3; r++)
		begin
			if ((relY >= displayPkg::digitRowY[r]) &&
				(relY < displayPkg::digitRowY[r] + displayPkg::cellSize))
			begin
				rowHit = 1'b1;
				rowIdx = 2'(r);
				rowOff = 4'(relY - displayPkg::digitRowY[r]);
			end
		end
	end

	always_comb
	begin
		colHit = 1'b0;
		colIdx = '0;
		colOff = '0;
		for (int c = 0; c < 6; c++)
		begin
			if ((relX >= displayPkg::digitColX[c]) &&
				(relX < displayPkg::digitColX[c] + displayPkg::cellSize))
			begin
				colHit = 1'b1;
				colIdx = 3'(c);
				colOff = 4'(relX - displayPkg::digitColX[c]);
			end
		end
	end

	// Even cell takes the tens nibble, odd cell the units nibble
	assign nibble = 4'(rowValue[rowIdx] >> (5'd20 - {colIdx, 2'b00}));

	////////////////////////////////////////
	// Pixel class
	always_comb
	begin
		if (!scan.videoOn)
			pixClass = displayPkg::PIX_BLANK;
		else if (!inPanel)
			pixClass = displayPkg::PIX_OUTSIDE;
		else if (rowHit && colHit && (nibble <= 4'd9))
			pixClass = displayPkg::PIX_DIGIT;
		else
			pixClass = displayPkg::PIX_PANEL;       // Background, or a nibble above 9
	end

	always_ff @(posedge CLK)
	begin
		if (rst)
			req <= displayPkg::reqIdle;
		else if (pixelTick)
		begin
			req.scan     <= scan;
			req.pixClass <= pixClass;
			req.digit    <= (pixClass == displayPkg::PIX_DIGIT) ? nibble : 4'd0;  // Keeps ROM in range
			req.glyphRow <= 3'(rowOff / displayPkg::glyphScale);  // Undo the 2x scaling
			req.glyphCol <= 3'(colOff / displayPkg::glyphScale);
		end
	end

endmodule

`default_nettype wire

// ==== glyphRom.sv ====
// Glyph ROM: ten 8x8 digit glyphs, registered bit lookup carrying the request along
`timescale 1ns/1ps
`default_nettype none

module glyphRom
(
	input  wire                      CLK,
	input  wire                      pixelTick,
	input  wire displayPkg::glyphReqT req,
	output displayPkg::glyphWordT    word       // Request plus the selected glyph bit
);

	logic [7:0] glyphMem [0:displayPkg::glyphDepth-1];  // Bit 7 is the leftmost column
	logic [6:0] romAddr;
	logic [7:0] rowBits;

	initial
	begin
		$readmemh("digitGlyphs.mem", glyphMem);
	end

	assign romAddr = 7'(req.digit * displayPkg::glyphSize + req.glyphRow);  // Eight rows per digit
	assign rowBits = glyphMem[romAddr];

	always_ff @(posedge CLK)
	begin
		if (pixelTick)
		begin
			word.req      <= req;                   // Same pixel as the bit below
			word.glyphBit <= rowBits[3'd7 - req.glyphCol];
		end
	end

endmodule

`default_nettype wire

// ==== pixelOutput.sv ====
// Pixel output stage: colour select, registered colour with aligned sync and position
`timescale 1ns/1ps
`default_nettype none

module pixelOutput
(
	input  wire                       CLK,
	input  wire                       rst,
	input  wire                       pixelTick,
	input  wire displayPkg::glyphWordT word,
	output displayPkg::colorT         COLOR,
	output logic                      HS,       // Active low
	output logic                      VS,       // Active low
	output logic                      videoOn,
	output displayPkg::coordT         pixelX,
	output displayPkg::coordT         pixelY
);

	displayPkg::colorT pixColor;

	always_comb
	begin
		case (word.req.pixClass)
			displayPkg::PIX_BLANK:   pixColor = displayPkg::colorBlank;
			displayPkg::PIX_OUTSIDE: pixColor = displayPkg::colorOutside;
			displayPkg::PIX_PANEL:   pixColor = displayPkg::colorPanel;
			displayPkg::PIX_DIGIT:   pixColor = word.glyphBit ? displayPkg::colorInk :
				displayPkg::colorPanel;             // Clear bits show the panel
			default:                 pixColor = displayPkg::colorBlank;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			COLOR   <= displayPkg::colorBlank;      // Outputs inactive
			HS      <= 1'b1;
			VS      <= 1'b1;
			videoOn <= 1'b0;
			pixelX  <= '0;
			pixelY  <= '0;
		end
		else if (pixelTick)
		begin
			COLOR   <= pixColor;
			HS      <= word.req.scan.hSync;         // Same stage as the colour
			VS      <= word.req.scan.vSync;
			videoOn <= word.req.scan.videoOn;
			pixelX  <= word.req.scan.x;
			pixelY  <= word.req.scan.y;
		end
	end

endmodule

`default_nettype wire

// ==== scanTiming.sv ====
// Scan generator: pixel strobe, horizontal and vertical counters, registered sync and position
`timescale 1ns/1ps
`default_nettype none

module scanTiming
(
	input  wire              CLK,
	input  wire              rst,
	output logic             pixelTick,             // One CLK in every pixelDivide
	output displayPkg::scanT scan                   // Registered position and syncs
);

	logic [displayPkg::pixelPhaseBits-1:0] phase;   // Position inside the pixel period
	displayPkg::coordT hCount;                      // Current column
	displayPkg::coordT vCount;                      // Current line
	logic lineEnd;
	logic frameEnd;

	////////////////////////////////////////
	// Pixel strobe
	// Phase rests at zero in reset, so the strobe keeps running and flushes idle data downstream
	assign pixelTick = (phase == '0);

	always_ff @(posedge CLK)
	begin
		if (rst)
			phase <= '0;
		else if (phase == displayPkg::phaseLast)
			phase <= '0;                            // Wrap after the last CLK of the pixel
		else
			phase <= phase + 1'b1;
	end

	////////////////////////////////////////
	// Counters
	assign lineEnd  = (hCount == displayPkg::hTotal - 1'b1);  // Column 799
	assign frameEnd = (vCount == displayPkg::vTotal - 1'b1);  // Line 524

	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			hCount <= '0;
			vCount <= '0;
			scan   <= displayPkg::scanIdle;         // Syncs high, video off
		end
		else if (pixelTick)
		begin
			hCount <= lineEnd ? '0 : hCount + 1'b1;
			if (lineEnd)
				vCount <= frameEnd ? '0 : vCount + 1'b1;  // Step line on column wrap

			// All scan fields come from the same counter values
			scan.x       <= hCount;
			scan.y       <= vCount;
			scan.hSync   <= !((hCount >= displayPkg::hSyncStart) &&
				(hCount < displayPkg::hSyncEnd));   // Low for 656..751
			scan.vSync   <= !((vCount >= displayPkg::vSyncStart) &&
				(vCount < displayPkg::vSyncEnd));   // Low for 490..491
			scan.videoOn <= (hCount < displayPkg::hActive) && (vCount < displayPkg::vActive);
		end
	end

endmodule

`default_nettype wire
